// File: source/usb_hid_pkg.sv
/*
 * Device-level definitions for the HID report unit.
 * Only boot keyboards and mice are told apart by protocol. Any other HID
 * subclass counts as a gamepad, and non-HID devices give no type.
 */
package usb_hid_pkg;

    // attached device kind, also the encoding on typ_o
    typedef enum logic [1:0] {
        DEV_NONE     = 2'd0,
        DEV_KEYBOARD = 2'd1,
        DEV_MOUSE    = 2'd2,
        DEV_GAMEPAD  = 2'd3
    } dev_type_t;

    localparam int HID_BUF_BYTES = 8;  // longest report that is kept
    localparam int HID_IDX_W     = 3;  // byte index inside a report

    typedef logic [7:0] hid_byte_t;

    // last response, byte 0 in the low bits
    typedef hid_byte_t [HID_BUF_BYTES-1:0] hid_buf_t;

    // descriptor registers written by the save pulses
    localparam logic [HID_IDX_W-1:0] DESC_REG_CLASS    = 3'd4;
    localparam logic [HID_IDX_W-1:0] DESC_REG_SUBCLASS = 3'd5;
    localparam logic [HID_IDX_W-1:0] DESC_REG_PROTOCOL = 3'd6;

    // interface descriptor codes
    localparam hid_byte_t CLASS_HID         = 8'd3;
    localparam hid_byte_t SUBCLASS_BOOT     = 8'd1;
    localparam hid_byte_t PROTOCOL_KEYBOARD = 8'd1;  // boot mouse is 2, any non-1 maps to mouse

endpackage

// File: source/hid_layout_pkg.sv
/*
 * Report layouts for boot keyboard, boot mouse and generic gamepad.
 * Gamepad positions follow the common layout with axes in bytes 3 and 4.
 * Some pads put the axes in bytes 0 and 1 instead, and both are decoded.
 */
package hid_layout_pkg;

    // keyboard boot report, byte 1 is reserved
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] KBD_MOD_POS       = 3'd0;
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] KBD_KEY_FIRST_POS = 3'd2;
    localparam int KBD_KEYS     = 4;  // keys kept out of the six in the report
    localparam int KBD_KEY_SEL_W = $clog2(KBD_KEYS);

    // mouse boot report
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] MOUSE_BTN_POS = 3'd0;
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] MOUSE_DX_POS  = 3'd1;
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] MOUSE_DY_POS  = 3'd2;

    // gamepad report
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] GP_ALT_X_POS = 3'd0;
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] GP_ALT_Y_POS = 3'd1;
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] GP_X_POS     = 3'd3;
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] GP_Y_POS     = 3'd4;
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] GP_BTN_POS   = 3'd5;
    localparam logic [usb_hid_pkg::HID_IDX_W-1:0] GP_SYS_POS   = 3'd6;

    localparam logic [1:0] GP_SKIP_TAG = 2'b10;  // adapter marks an unrelated record
    localparam usb_hid_pkg::hid_byte_t GP_AXIS_MIN = 8'h00;
    localparam usb_hid_pkg::hid_byte_t GP_AXIS_MAX = 8'hFF;

    typedef struct packed {
        usb_hid_pkg::hid_byte_t                mods;
        usb_hid_pkg::hid_byte_t [KBD_KEYS-1:0] keys;  // keys[0] is key 1
    } kbd_state_t;

    typedef struct packed {
        usb_hid_pkg::hid_byte_t btn;  // {5'bx, middle, right, left}
        logic signed [7:0]      dx;
        logic signed [7:0]      dy;
    } mouse_state_t;

    typedef struct packed {
        logic l, r, u, d;
        logic a, b, x, y;
        logic sel, sta;
    } gp_state_t;

endpackage

// File: source/hid_byte_if.sv
/*
 * Byte events of one report frame, from the capture stage to the decoders.
 * byte_valid and frame_end are single-cycle; there is no back-pressure.
 */
interface hid_byte_if;

    logic                                 byte_valid;  // one byte this cycle
    logic [usb_hid_pkg::HID_IDX_W-1:0]    byte_idx;    // position inside the frame
    usb_hid_pkg::hid_byte_t               byte_data;
    logic                                 frame_end;   // frame level just dropped

    modport capture (
        output byte_valid, byte_idx, byte_data, frame_end
    );

    modport sink (
        input byte_valid, byte_idx, byte_data, frame_end
    );

    modport frame_mon (
        input frame_end
    );

endinterface

// File: source/hid_rx_capture.sv
/*
 * Turns the engine's frame level and byte strobe into byte events.
 * A byte counts once, on the rising strobe while frame_i is high.
 * Bytes past the eighth wrap onto the start of the buffer.
 */
module hid_rx_capture (
    input  logic                       usbclk,
    input  logic                       usbrst_n,
    input  logic                       frame_i,
    input  logic                       byte_stb_i,
    input  usb_hid_pkg::hid_byte_t     byte_i,
    hid_byte_if.capture                bus,
    output usb_hid_pkg::hid_buf_t      buf_o
);

    logic                              stb_q;    // strobe one cycle back
    logic                              frame_q;  // frame level one cycle back
    logic [usb_hid_pkg::HID_IDX_W-1:0] idx_q;
    usb_hid_pkg::hid_buf_t             buf_q;
    logic                              byte_evt;

    assign byte_evt = frame_i & byte_stb_i & ~stb_q;

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            stb_q   <= 1'b0;
            frame_q <= 1'b0;
        end else begin
            stb_q   <= byte_stb_i;
            frame_q <= frame_i;
        end
    end

    // byte position, back to 0 between frames
    always_ff @(posedge usbclk) begin
        if (!usbrst_n || !frame_i) begin
            idx_q <= '0;
        end else if (byte_evt) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // last response, visible on hid_report_o
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            buf_q <= '0;
        end else if (byte_evt) begin
            buf_q[idx_q] <= byte_i;
        end
    end

    assign bus.byte_valid = byte_evt;
    assign bus.byte_idx   = idx_q;
    assign bus.byte_data  = byte_i;
    assign bus.frame_end  = frame_q & ~frame_i;  // falling edge of the frame

    assign buf_o = buf_q;

endmodule

// File: source/hid_type_classifier.sv
/*
 * Device type from the interface class, subclass and protocol bytes.
 * The decision is taken when a save aimed at the protocol register ends,
 * so the engine must save class and subclass before protocol.
 */
module hid_type_classifier (
    input  logic                              usbclk,
    input  logic                              usbrst_n,
    input  logic                              save_i,
    input  logic [usb_hid_pkg::HID_IDX_W-1:0] save_reg_i,
    input  logic [usb_hid_pkg::HID_IDX_W-1:0] save_idx_i,
    input  usb_hid_pkg::hid_buf_t             buf_i,
    input  logic                              connected_i,
    output usb_hid_pkg::dev_type_t            dev_type_o
);

    usb_hid_pkg::hid_byte_t              class_q;
    usb_hid_pkg::hid_byte_t              subclass_q;
    usb_hid_pkg::hid_byte_t              protocol_q;
    logic                                save_q;
    logic [usb_hid_pkg::HID_IDX_W-1:0]   last_reg_q;  // target of the latest save
    logic                                connected_q;
    usb_hid_pkg::dev_type_t              type_q;
    usb_hid_pkg::dev_type_t              type_next;
    logic                                decide;

    // other register indices are ignored here
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            class_q    <= '0;
            subclass_q <= '0;
            protocol_q <= '0;
        end else if (save_i) begin
            case (save_reg_i)
                usb_hid_pkg::DESC_REG_CLASS:    class_q    <= buf_i[save_idx_i];
                usb_hid_pkg::DESC_REG_SUBCLASS: subclass_q <= buf_i[save_idx_i];
                usb_hid_pkg::DESC_REG_PROTOCOL: protocol_q <= buf_i[save_idx_i];
                default: ;
            endcase
        end
    end

    assign decide = save_q & ~save_i & (last_reg_q == usb_hid_pkg::DESC_REG_PROTOCOL);

    always_comb begin
        if (class_q != usb_hid_pkg::CLASS_HID) begin
            type_next = usb_hid_pkg::DEV_NONE;
        end else if (subclass_q == usb_hid_pkg::SUBCLASS_BOOT) begin
            type_next = (protocol_q == usb_hid_pkg::PROTOCOL_KEYBOARD) ?
                        usb_hid_pkg::DEV_KEYBOARD : usb_hid_pkg::DEV_MOUSE;
        end else begin
            type_next = usb_hid_pkg::DEV_GAMEPAD;  // non-boot HID
        end
    end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            save_q      <= 1'b0;
            last_reg_q  <= '0;
            connected_q <= 1'b0;
            type_q      <= usb_hid_pkg::DEV_NONE;
        end else begin
            save_q      <= save_i;
            connected_q <= connected_i;
            if (save_i) last_reg_q <= save_reg_i;
            if (decide) type_q <= type_next;
            if (connected_q && !connected_i) type_q <= usb_hid_pkg::DEV_NONE;  // unplug wins
        end
    end

    assign dev_type_o = type_q;

endmodule

// File: source/hid_boot_decoder.sv
/*
 * Boot protocol keyboard and mouse fields.
 * Keys 5 and 6 of the keyboard report are dropped.
 * Mouse motion is relative, so dx and dy read zero after each report pulse.
 */
module hid_boot_decoder (
    input  logic                          usbclk,
    input  logic                          usbrst_n,
    hid_byte_if.sink                      bus,
    input  usb_hid_pkg::dev_type_t        dev_type_i,
    input  logic                          clear_motion_i,
    output hid_layout_pkg::kbd_state_t    kbd_o,
    output hid_layout_pkg::mouse_state_t  mouse_o
);

    hid_layout_pkg::kbd_state_t          kbd_q;
    hid_layout_pkg::mouse_state_t        mouse_q;
    logic [usb_hid_pkg::HID_IDX_W-1:0]   key_off;  // offset from the first key byte

    assign key_off = bus.byte_idx - hid_layout_pkg::KBD_KEY_FIRST_POS;

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            kbd_q <= '0;
        end else if (bus.byte_valid && dev_type_i == usb_hid_pkg::DEV_KEYBOARD) begin
            if (bus.byte_idx == hid_layout_pkg::KBD_MOD_POS) begin
                kbd_q.mods <= bus.byte_data;
            end
            // bytes below the first key wrap to a large offset
            if (key_off < hid_layout_pkg::KBD_KEYS) begin
                kbd_q.keys[key_off[hid_layout_pkg::KBD_KEY_SEL_W-1:0]] <= bus.byte_data;
            end
        end
    end

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            mouse_q <= '0;
        end else begin
            if (clear_motion_i) begin
                mouse_q.dx <= '0;
                mouse_q.dy <= '0;
            end
            if (bus.byte_valid && dev_type_i == usb_hid_pkg::DEV_MOUSE) begin
                case (bus.byte_idx)
                    hid_layout_pkg::MOUSE_BTN_POS: mouse_q.btn <= bus.byte_data;
                    hid_layout_pkg::MOUSE_DX_POS:  mouse_q.dx  <= bus.byte_data;
                    hid_layout_pkg::MOUSE_DY_POS:  mouse_q.dy  <= bus.byte_data;
                    default: ;  // wheel and vendor bytes
                endcase
            end
        end
    end

    assign kbd_o   = kbd_q;
    assign mouse_o = mouse_q;

endmodule

// File: source/hid_gamepad_decoder.sv
/*
 * Generic gamepad decoding for the common cheap pad layouts.
 * Directions from an axis count only near the ends of its range.
 * Records whose first byte carries the skip tag keep the previous
 * buttons and main-axis directions.
 */
module hid_gamepad_decoder (
    input  logic                       usbclk,
    input  logic                       usbrst_n,
    hid_byte_if.sink                   bus,
    input  usb_hid_pkg::dev_type_t     dev_type_i,
    output hid_layout_pkg::gp_state_t  gp_o
);

    hid_layout_pkg::gp_state_t  gp_q;
    logic                       valid_q;  // current record is a real report
    logic                       gp_evt;
    logic [1:0]                 axis_top; // top two bits of a main axis byte

    assign gp_evt   = bus.byte_valid & (dev_type_i == usb_hid_pkg::DEV_GAMEPAD);
    assign axis_top = bus.byte_data[7:6];

    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            gp_q    <= '0;
            valid_q <= 1'b0;
        end else if (gp_evt) begin
            case (bus.byte_idx)
                hid_layout_pkg::GP_ALT_X_POS: begin
                    if (bus.byte_data[1:0] != hid_layout_pkg::GP_SKIP_TAG) begin
                        valid_q <= 1'b1;
                        gp_q.l  <= 1'b0;
                        gp_q.r  <= 1'b0;
                        gp_q.u  <= 1'b0;
                        gp_q.d  <= 1'b0;
                    end else begin
                        valid_q <= 1'b0;
                    end
                    // pads with the x axis in byte 0, the extremes win over the clear
                    if (bus.byte_data == hid_layout_pkg::GP_AXIS_MIN) {gp_q.l, gp_q.r} <= 2'b10;
                    if (bus.byte_data == hid_layout_pkg::GP_AXIS_MAX) {gp_q.l, gp_q.r} <= 2'b01;
                end
                hid_layout_pkg::GP_ALT_Y_POS: begin
                    if (bus.byte_data == hid_layout_pkg::GP_AXIS_MIN) {gp_q.u, gp_q.d} <= 2'b10;
                    if (bus.byte_data == hid_layout_pkg::GP_AXIS_MAX) {gp_q.u, gp_q.d} <= 2'b01;
                end
                hid_layout_pkg::GP_X_POS: if (valid_q) begin
                    if (axis_top == 2'b00) {gp_q.l, gp_q.r} <= 2'b10;
                    if (axis_top == 2'b11) {gp_q.l, gp_q.r} <= 2'b01;
                end
                hid_layout_pkg::GP_Y_POS: if (valid_q) begin
                    if (axis_top == 2'b00) {gp_q.u, gp_q.d} <= 2'b10;
                    if (axis_top == 2'b11) {gp_q.u, gp_q.d} <= 2'b01;
                end
                hid_layout_pkg::GP_BTN_POS: if (valid_q) begin
                    gp_q.x <= bus.byte_data[4];
                    gp_q.a <= bus.byte_data[5];
                    gp_q.b <= bus.byte_data[6];
                    gp_q.y <= bus.byte_data[7];
                end
                hid_layout_pkg::GP_SYS_POS: if (valid_q) begin
                    gp_q.sel <= bus.byte_data[4];
                    gp_q.sta <= bus.byte_data[5];
                end
                default: ;  // byte 2 and 7 carry nothing we use
            endcase
        end
    end

    assign gp_o = gp_q;

endmodule

// File: source/usb_hid_report_unit.sv
/*
 * Report interpretation side of a low-speed USB HID host.
 * Expects the byte stream, save pulses and connection level of a USB engine.
 * Fields are valid by typ_o (1 keyboard, 2 mouse, 3 gamepad) when report_o pulses.
 */
module usb_hid_report_unit (
    input  logic              usbclk,
    input  logic              usbrst_n,
    input  logic              frame_i,       // high while a frame is delivered
    input  logic              byte_stb_i,
    input  logic [7:0]        byte_i,
    input  logic              save_i,
    input  logic [2:0]        save_reg_i,
    input  logic [2:0]        save_idx_i,
    input  logic              connected_i,
    output logic [1:0]        typ_o,
    output logic              report_o,
    output logic [7:0]        key_modifiers_o,
    output logic [7:0]        key1_o,
    output logic [7:0]        key2_o,
    output logic [7:0]        key3_o,
    output logic [7:0]        key4_o,
    output logic [7:0]        mouse_btn_o,
    output logic signed [7:0] mouse_dx_o,    // cleared after report_o
    output logic signed [7:0] mouse_dy_o,    // cleared after report_o
    output logic              game_l_o,
    output logic              game_r_o,
    output logic              game_u_o,
    output logic              game_d_o,
    output logic              game_a_o,
    output logic              game_b_o,
    output logic              game_x_o,
    output logic              game_y_o,
    output logic              game_sel_o,
    output logic              game_sta_o,
    output logic [63:0]       hid_report_o   // last response, byte 0 low
);

    usb_hid_pkg::hid_buf_t         resp_buf;
    usb_hid_pkg::dev_type_t        dev_type;
    hid_layout_pkg::kbd_state_t    kbd;
    hid_layout_pkg::mouse_state_t  mouse;
    hid_layout_pkg::gp_state_t     gp;
    logic                          report_q;

    hid_byte_if byte_bus ();

    hid_rx_capture i_rx_capture (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .frame_i    (frame_i),
        .byte_stb_i (byte_stb_i),
        .byte_i     (byte_i),
        .bus        (byte_bus.capture),
        .buf_o      (resp_buf)
    );

    hid_type_classifier i_type_classifier (
        .usbclk      (usbclk),
        .usbrst_n    (usbrst_n),
        .save_i      (save_i),
        .save_reg_i  (save_reg_i),
        .save_idx_i  (save_idx_i),
        .buf_i       (resp_buf),
        .connected_i (connected_i),
        .dev_type_o  (dev_type)
    );

    hid_boot_decoder i_boot_decoder (
        .usbclk         (usbclk),
        .usbrst_n       (usbrst_n),
        .bus            (byte_bus.sink),
        .dev_type_i     (dev_type),
        .clear_motion_i (report_q),
        .kbd_o          (kbd),
        .mouse_o        (mouse)
    );

    hid_gamepad_decoder i_gamepad_decoder (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .bus        (byte_bus.sink),
        .dev_type_i (dev_type),
        .gp_o       (gp)
    );

    // one pulse per frame, only once a device is known
    always_ff @(posedge usbclk) begin
        if (!usbrst_n) begin
            report_q <= 1'b0;
        end else begin
            report_q <= byte_bus.frame_end && (dev_type != usb_hid_pkg::DEV_NONE);
        end
    end

    assign typ_o    = dev_type;
    assign report_o = report_q;

    assign key_modifiers_o = kbd.mods;
    assign key1_o          = kbd.keys[0];
    assign key2_o          = kbd.keys[1];
    assign key3_o          = kbd.keys[2];
    assign key4_o          = kbd.keys[3];

    assign mouse_btn_o = mouse.btn;
    assign mouse_dx_o  = mouse.dx;
    assign mouse_dy_o  = mouse.dy;

    assign game_l_o   = gp.l;
    assign game_r_o   = gp.r;
    assign game_u_o   = gp.u;
    assign game_d_o   = gp.d;
    assign game_a_o   = gp.a;
    assign game_b_o   = gp.b;
    assign game_x_o   = gp.x;
    assign game_y_o   = gp.y;
    assign game_sel_o = gp.sel;
    assign game_sta_o = gp.sta;

    assign hid_report_o = resp_buf;

endmodule

// File: dv/hid_report_assertions.sv
/*
 * Checks on the report pulse of the HID report unit, bound to its top level.
 * Reset holds all checks off.
 */
module hid_report_assertions (
    input logic              usbclk,
    input logic              usbrst_n,
    input logic              report_o,
    input logic [1:0]        typ_o,
    input logic signed [7:0] mouse_dx_o,
    input logic signed [7:0] mouse_dy_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int len_fails = 0;
    int type_fails = 0;
    int motion_fails = 0;
    int fail_count;

    assign fail_count = len_fails + type_fails + motion_fails;  // sum of all failures

    report_one_cycle: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report_o |=> !report_o)
        else begin
            len_fails++;
            $error("report_o stayed high for more than one cycle");
        end

    report_needs_type: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        $rose(report_o) |-> typ_o != 2'd0)
        else begin
            type_fails++;
            $error("report_o rose while no device type is known");
        end

    // relative motion is consumed by the report
    motion_cleared: assert property (@(posedge usbclk) disable iff (!usbrst_n)
        report_o |=> (mouse_dx_o == 8'sd0 && mouse_dy_o == 8'sd0))
        else begin
            motion_fails++;
            $error("mouse motion not cleared after report_o");
        end

endmodule

// File: dv/hid_report_model.svh
/*
 * Reference model of the HID report unit, included in the testbench body.
 * Every frame is assumed to carry byte 0, which sets the gamepad record validity.
 */
`ifndef HID_REPORT_MODEL_SVH
`define HID_REPORT_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// class, subclass and protocol from the interface descriptor
function automatic usb_hid_pkg::dev_type_t ref_dev_type(
    input usb_hid_pkg::hid_byte_t cls, sub, prot);
    if (cls != 8'd3) return usb_hid_pkg::DEV_NONE;
    if (sub != 8'd1) return usb_hid_pkg::DEV_GAMEPAD;  // HID but not boot
    return (prot == 8'd1) ? usb_hid_pkg::DEV_KEYBOARD : usb_hid_pkg::DEV_MOUSE;
endfunction

function automatic hid_layout_pkg::kbd_state_t ref_keyboard(
    input hid_layout_pkg::kbd_state_t prev, input usb_hid_pkg::hid_buf_t rep, input int n);
    hid_layout_pkg::kbd_state_t s;
    s = prev;
    if (n > 0) s.mods = rep[0];
    for (int k = 0; k < 4; k++) begin
        if (n > k + 2) s.keys[k] = rep[k + 2];  // keys 5 and 6 are not kept
    end
    return s;
endfunction

function automatic hid_layout_pkg::mouse_state_t ref_mouse(
    input hid_layout_pkg::mouse_state_t prev, input usb_hid_pkg::hid_buf_t rep, input int n);
    hid_layout_pkg::mouse_state_t s;
    s = prev;
    if (n > 0) s.btn = rep[0];
    if (n > 1) s.dx = rep[1];
    if (n > 2) s.dy = rep[2];
    return s;
endfunction

// {neg, pos} pair of a main axis, kept for mid-range values
function automatic logic [1:0] axis_dir(input logic [1:0] prev, input usb_hid_pkg::hid_byte_t v);
    if (v[7:6] == 2'b00) return 2'b10;
    if (v[7:6] == 2'b11) return 2'b01;
    return prev;
endfunction

function automatic hid_layout_pkg::gp_state_t ref_gamepad(
    input hid_layout_pkg::gp_state_t prev, input usb_hid_pkg::hid_buf_t rep, input int n);
    hid_layout_pkg::gp_state_t s;
    logic valid;
    s = prev;
    valid = (n > 0) && (rep[0][1:0] != 2'b10);
    if (valid) {s.l, s.r, s.u, s.d} = 4'b0000;
    // alternate axes count whatever the validity
    if (n > 0 && rep[0] == 8'h00) {s.l, s.r} = 2'b10;
    if (n > 0 && rep[0] == 8'hFF) {s.l, s.r} = 2'b01;
    if (n > 1 && rep[1] == 8'h00) {s.u, s.d} = 2'b10;
    if (n > 1 && rep[1] == 8'hFF) {s.u, s.d} = 2'b01;
    if (valid && n > 3) {s.l, s.r} = axis_dir({s.l, s.r}, rep[3]);
    if (valid && n > 4) {s.u, s.d} = axis_dir({s.u, s.d}, rep[4]);
    if (valid && n > 5) {s.x, s.a, s.b, s.y} = {rep[5][4], rep[5][5], rep[5][6], rep[5][7]};
    if (valid && n > 6) {s.sel, s.sta} = {rep[6][4], rep[6][5]};
    return s;
endfunction

`endif

// File: dv/tb_usb_hid_report.sv
/*
 * Testbench of the HID report unit against the reference model.
 * Frames use strobes of two cycles high and two low.
 * Descriptor bytes sit in bytes 5 to 7 of their frame. The first wrong value ends the run.
 */
module tb_usb_hid_report;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_CLASS      = 12;
    localparam int N_KBD        = 10;
    localparam int N_MOUSE      = 10;
    localparam int N_GP         = 16;
    localparam int N_FRAMES     = N_CLASS + 3 + N_KBD + N_MOUSE + N_GP + 1;
    localparam int FRAME_CYCLES = 64;  // eight bytes, idle gap and three saves
    localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + N_FRAMES * FRAME_CYCLES) * CLK_PERIOD;

    logic usbclk, usbrst_n, frame_i, byte_stb_i, save_i, connected_i;
    logic [7:0] byte_i;
    logic [2:0] save_reg_i, save_idx_i;
    logic [1:0] typ_o;
    logic report_o;
    logic [7:0] key_modifiers_o, key1_o, key2_o, key3_o, key4_o, mouse_btn_o;
    logic signed [7:0] mouse_dx_o, mouse_dy_o;
    logic game_l_o, game_r_o, game_u_o, game_d_o, game_a_o;
    logic game_b_o, game_x_o, game_y_o, game_sel_o, game_sta_o;
    logic [63:0] hid_report_o;

    logic [31:0]                  rng_state = 32'd33;
    usb_hid_pkg::dev_type_t       cur_type = usb_hid_pkg::DEV_NONE;
    usb_hid_pkg::hid_buf_t        exp_buf = '0;
    hid_layout_pkg::kbd_state_t   exp_kbd = '0;
    hid_layout_pkg::mouse_state_t exp_mouse = '0;
    hid_layout_pkg::gp_state_t    exp_gp = '0;
    int                           exp_reports = 0;
    int                           report_count = 0;

    `include "hid_report_model.svh"

    usb_hid_report_unit i_usb_hid_report_unit (.*);

    bind usb_hid_report_unit hid_report_assertions i_report_assertions (
        .usbclk     (usbclk),
        .usbrst_n   (usbrst_n),
        .report_o   (report_o),
        .typ_o      (typ_o),
        .mouse_dx_o (mouse_dx_o),
        .mouse_dy_o (mouse_dy_o)
    );

    function automatic usb_hid_pkg::hid_byte_t rand_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[15:8];
    endfunction

    function automatic int rand_below(input int n);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % n);
    endfunction

    function automatic usb_hid_pkg::hid_buf_t random_frame();
        usb_hid_pkg::hid_buf_t f;
        for (int k = 0; k < 8; k++) f[k] = rand_byte();
        return f;
    endfunction

    function automatic usb_hid_pkg::hid_byte_t axis_byte();
        usb_hid_pkg::hid_byte_t r;
        r = rand_byte();
        case (rand_below(4))
            0: return {2'b00, r[5:0]};
            1: return {2'b11, r[5:0]};
            2: return 8'h80;  // centered stick
            default: return r;
        endcase
    endfunction

    function automatic usb_hid_pkg::hid_buf_t gamepad_frame();
        usb_hid_pkg::hid_buf_t f;
        usb_hid_pkg::hid_byte_t r;
        f = random_frame();
        r = rand_byte();
        case (rand_below(4))
            0: f[0] = 8'h00;
            1: f[0] = 8'hFF;
            2: f[0] = {r[7:2], 2'b10};  // skipped record
            default: ;
        endcase
        case (rand_below(3))
            0: f[1] = 8'h00;
            1: f[1] = 8'hFF;
            default: ;
        endcase
        f[3] = axis_byte();
        f[4] = axis_byte();
        return f;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic send_frame(input usb_hid_pkg::hid_buf_t data, input int n);
        case (cur_type)
            usb_hid_pkg::DEV_KEYBOARD: exp_kbd = ref_keyboard(exp_kbd, data, n);
            usb_hid_pkg::DEV_MOUSE:    exp_mouse = ref_mouse(exp_mouse, data, n);
            usb_hid_pkg::DEV_GAMEPAD:  exp_gp = ref_gamepad(exp_gp, data, n);
            default: ;
        endcase
        for (int k = 0; k < n; k++) exp_buf[k] = data[k];
        @(posedge usbclk);
        frame_i <= 1'b1;
        for (int k = 0; k < n; k++) begin
            @(posedge usbclk);
            byte_i     <= data[k];
            byte_stb_i <= 1'b1;
            repeat (2) @(posedge usbclk);
            byte_stb_i <= 1'b0;
            @(posedge usbclk);
        end
        @(posedge usbclk);
        frame_i <= 1'b0;
        repeat (6) @(posedge usbclk);  // report and motion checks finish here
        if (cur_type != usb_hid_pkg::DEV_NONE) begin
            exp_reports++;
            exp_mouse.dx = '0;
            exp_mouse.dy = '0;
        end
    endtask

    task automatic save_desc(input logic [2:0] reg_sel, input logic [2:0] idx);
        @(posedge usbclk);
        save_i     <= 1'b1;
        save_reg_i <= reg_sel;
        save_idx_i <= idx;
        @(posedge usbclk);
        save_i <= 1'b0;
        @(posedge usbclk);
    endtask

    task automatic classify(input usb_hid_pkg::hid_byte_t cls, sub, prot);
        usb_hid_pkg::hid_buf_t desc;
        desc    = random_frame();
        desc[5] = cls;
        desc[6] = sub;
        desc[7] = prot;
        send_frame(desc, 8);
        save_desc(3'd4, 3'd5);
        save_desc(3'd5, 3'd6);
        save_desc(3'd6, 3'd7);
        cur_type = ref_dev_type(cls, sub, prot);
        repeat (2) @(posedge usbclk);
        @(negedge usbclk);
        check_value("typ_o", 64'(typ_o), 64'(cur_type));
    endtask

    initial begin
        usbclk = 1'b0;
        forever #(CLK_PERIOD / 2) usbclk = ~usbclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: stimulus still running after %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // every report pulse is checked against the model
    initial begin : compare_reports
        forever begin
            @(negedge usbclk);
            if (report_o === 1'b1) begin
                report_count++;
                check_value("typ_o", 64'(typ_o), 64'(cur_type));
                check_value("hid_report_o", hid_report_o, exp_buf);
                check_value("key_modifiers_o", 64'(key_modifiers_o), 64'(exp_kbd.mods));
                check_value("key4_o..key1_o", 64'({key4_o, key3_o, key2_o, key1_o}),
                            64'(exp_kbd.keys));
                check_value("mouse_btn_o", 64'(mouse_btn_o), 64'(exp_mouse.btn));
                check_value("mouse_dx_o", 64'($unsigned(mouse_dx_o)),
                            64'($unsigned(exp_mouse.dx)));
                check_value("mouse_dy_o", 64'($unsigned(mouse_dy_o)),
                            64'($unsigned(exp_mouse.dy)));
                check_value("game_l_o..game_sta_o", 64'({game_l_o, game_r_o, game_u_o,
                            game_d_o, game_a_o, game_b_o, game_x_o, game_y_o, game_sel_o,
                            game_sta_o}), 64'(exp_gp));
                @(negedge usbclk);
                check_value("report_o", 64'(report_o), 64'd0);
                check_value("mouse_dx_o", 64'($unsigned(mouse_dx_o)), 64'd0);
                check_value("mouse_dy_o", 64'($unsigned(mouse_dy_o)), 64'd0);
            end
        end
    end

    initial begin : stimulus
        usb_hid_pkg::hid_byte_t cls;
        usb_hid_pkg::hid_byte_t sub;
        usb_hid_pkg::hid_byte_t prot;
        usbrst_n    = 1'b0;
        frame_i     = 1'b0;
        byte_stb_i  = 1'b0;
        byte_i      = '0;
        save_i      = 1'b0;
        save_reg_i  = '0;
        save_idx_i  = '0;
        connected_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge usbclk);
        usbrst_n    <= 1'b1;
        connected_i <= 1'b1;
        @(negedge usbclk);
        check_value("typ_o", 64'(typ_o), 64'd0);
        check_value("report_o", 64'(report_o), 64'd0);
        check_value("hid_report_o", hid_report_o, 64'd0);
        check_value("key_modifiers_o", 64'(key_modifiers_o), 64'd0);
        check_value("key4_o..key1_o", 64'({key4_o, key3_o, key2_o, key1_o}), 64'd0);
        check_value("mouse_btn_o", 64'(mouse_btn_o), 64'd0);
        check_value("mouse_dx_o", 64'($unsigned(mouse_dx_o)), 64'd0);
        check_value("mouse_dy_o", 64'($unsigned(mouse_dy_o)), 64'd0);
        check_value("game_l_o..game_sta_o", 64'({game_l_o, game_r_o, game_u_o,
                    game_d_o, game_a_o, game_b_o, game_x_o, game_y_o, game_sel_o,
                    game_sta_o}), 64'd0);

        for (int i = 0; i < N_CLASS; i++) begin
            cls  = (rand_below(2) == 0) ? 8'd3 : rand_byte();
            sub  = (rand_below(2) == 0) ? 8'd1 : rand_byte();
            prot = (rand_below(3) == 0) ? rand_byte() : 8'(1 + rand_below(2));
            classify(cls, sub, prot);
        end

        classify(8'd3, 8'd1, 8'd1);  // boot keyboard
        for (int i = 0; i < N_KBD; i++) send_frame(random_frame(), 6);
        classify(8'd3, 8'd1, 8'd2);  // boot mouse
        for (int i = 0; i < N_MOUSE; i++) send_frame(random_frame(), 3 + rand_below(2));
        classify(8'd3, 8'd0, 8'd0);  // non-boot HID
        for (int i = 0; i < N_GP; i++) send_frame(gamepad_frame(), 8);

        // unplug and send a frame that must not report
        @(posedge usbclk);
        connected_i <= 1'b0;
        repeat (2) @(posedge usbclk);
        @(negedge usbclk);
        cur_type = usb_hid_pkg::DEV_NONE;
        check_value("typ_o", 64'(typ_o), 64'd0);
        send_frame(random_frame(), 8);
        check_value("report_o pulse count", 64'(report_count), 64'(exp_reports));

        if (i_usb_hid_report_unit.i_report_assertions.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

// File: filelist.f
+incdir+dv
source/usb_hid_pkg.sv
source/hid_layout_pkg.sv
source/hid_byte_if.sv
source/hid_rx_capture.sv
source/hid_type_classifier.sv
source/hid_boot_decoder.sv
source/hid_gamepad_decoder.sv
source/usb_hid_report_unit.sv
dv/hid_report_assertions.sv
dv/tb_usb_hid_report.sv

// File: run_sim.sh
#!/bin/sh
# build and run the HID report unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps --top-module tb_usb_hid_report \
    -f filelist.f -o tb_usb_hid_report
output=$(./obj_dir/tb_usb_hid_report 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
    exit 0
fi
echo "simulation did not pass"
exit 1
